// File: ppu_regs_pkg.sv
package ppu_regs_pkg;

	// Scroll register value, or a line or column coordinate.
	typedef logic [7:0] scroll_t;

	// Background palette. The shade for color index n sits at bits 2n+1:2n.
	typedef logic [7:0] palette_t;

	// A color index before the palette, or a shade after it.
	typedef logic [1:0] color_t;

	// Visible pixels per line.
	localparam int SCREEN_WIDTH = 160;

	// Pixels in one tile row.
	localparam int TILE_PIXELS = 8;

	// One tile more than the screen holds, so a fine scroll never runs short of pixels.
	localparam int TILES_PER_LINE = SCREEN_WIDTH / TILE_PIXELS + 1;

endpackage

// File: ppu_vram_pkg.sv
package ppu_vram_pkg;

	typedef logic [12:0] vram_addr_t;
	typedef logic [7:0]  vram_data_t;
	typedef logic [7:0]  tile_index_t;

	// Size of video RAM in bytes.
	localparam int VRAM_BYTES = 8192;

	// Tile map bases, picked by the map select bit.
	localparam vram_addr_t MAP_BASE_LOW  = 13'h1800;
	localparam vram_addr_t MAP_BASE_HIGH = 13'h1C00;

	// Tile data bases. With data select at 1 the index is unsigned from 0x0000.
	// With data select at 0 it is signed around 0x1000.
	localparam vram_addr_t DATA_BASE_UNSIGNED = 13'h0000;
	localparam vram_addr_t DATA_BASE_SIGNED   = 13'h1000;

	// Per-tile fetch sequence.
	typedef enum logic [2:0] {
		IDLE,
		MAP,
		DATA_LOW,
		DATA_HIGH,
		HOLD
	} fetch_state_t;

endpackage

// File: vram.sv
`timescale 1ns/1ps

module vram import ppu_vram_pkg::*; (
		input  logic       clkpipe,
		input  logic       we,
		input  vram_addr_t waddr,
		input  vram_data_t wdata,
		input  vram_addr_t raddr,
		output vram_data_t rdata
	);

	vram_data_t mem [VRAM_BYTES];

	// Write port, used by the loader between lines.
	always_ff @(posedge clkpipe) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Registered read. The byte for an address shows up one cycle later.
	always_ff @(posedge clkpipe) begin
		rdata <= mem[raddr];
	end

endmodule

// File: bg_scroll_addr.sv
`timescale 1ns/1ps

module bg_scroll_addr import ppu_regs_pkg::*, ppu_vram_pkg::*; (
		input  scroll_t     line,
		input  scroll_t     scy,
		input  scroll_t     scx,
		input  logic [4:0]  tile_col,
		input  logic        map_sel,
		input  logic        data_sel,
		input  logic        addr_sel,
		input  logic        plane_high,
		input  tile_index_t tile_index,
		output vram_addr_t  rd_addr
	);

	scroll_t    v_sum;
	scroll_t    h_sum;
	vram_addr_t map_base;
	vram_addr_t map_addr;
	vram_addr_t data_base;
	vram_addr_t tile_offset;
	vram_addr_t row_offset;
	vram_addr_t data_addr;

	// Both sums wrap at 256, so the map wraps around on both axes.
	assign v_sum = line + scy;
	assign h_sum = scx + {tile_col, 3'b000};

	// Map address: 32 tiles per map row.
	assign map_base = map_sel ? MAP_BASE_HIGH : MAP_BASE_LOW;
	assign map_addr = map_base + {3'b000, v_sum[7:3], h_sum[7:3]};

	// Each tile is 16 bytes, two per pixel row. In signed mode the index is sign
	// extended so that 0x80..0xFF land below the 0x1000 base.
	assign data_base   = data_sel ? DATA_BASE_UNSIGNED : DATA_BASE_SIGNED;
	assign tile_offset = {(data_sel ? 1'b0 : tile_index[7]), tile_index, 4'b0000};
	assign row_offset  = {9'd0, v_sum[2:0], plane_high};
	assign data_addr   = data_base + tile_offset + row_offset;

	assign rd_addr = addr_sel ? data_addr : map_addr;

endmodule

// File: bg_fetcher.sv
`timescale 1ns/1ps

module bg_fetcher import ppu_regs_pkg::*, ppu_vram_pkg::*; (
		input  logic        clkpipe,
		input  logic        rst_n,
		input  logic        line_start,
		input  scroll_t     scx,
		input  vram_data_t  rd_data,
		output logic [4:0]  tile_col,
		output logic        addr_sel,
		output logic        plane_high,
		output tile_index_t tile_index,
		output logic        load,
		output logic        shift,
		output logic        emit,
		output vram_data_t  plane_low_byte,
		output vram_data_t  plane_high_byte,
		output logic        line_done
	);

	fetch_state_t state;
	tile_index_t  index_q;
	vram_data_t   high_q;
	logic         high_fresh;
	logic         running;
	logic [2:0]   shift_cnt;
	logic [2:0]   skip;
	logic [7:0]   pix_cnt;
	logic         last_pixel;
	logic         finish;

	// The map byte and the high plane byte are taken straight from the RAM
	// in the cycle they arrive, which keeps the first tile on time.
	assign tile_index      = (state == DATA_LOW) ? rd_data : index_q;
	assign plane_high_byte = high_fresh ? rd_data : high_q;

	// The map read is issued in IDLE and MAP, the data reads in the two DATA states.
	assign addr_sel   = (state == DATA_LOW) || (state == DATA_HIGH);
	assign plane_high = (state == DATA_HIGH);

	// Tile 0 loads as soon as it is ready. Later tiles wait for the eighth shift.
	assign load = (state == HOLD) && (tile_col != TILES_PER_LINE)
		&& ((tile_col == 5'd0) || (shift_cnt == TILE_PIXELS - 1));

	assign shift      = running;
	assign emit       = running && (skip == 3'd0);
	assign last_pixel = emit && (pix_cnt == SCREEN_WIDTH - 1);

	always_ff @(posedge clkpipe) begin
		if (!rst_n) begin
			state      <= IDLE;
			tile_col   <= '0;
			high_fresh <= 1'b0;
			running    <= 1'b0;
			shift_cnt  <= '0;
			skip       <= '0;
			pix_cnt    <= '0;
			finish     <= 1'b0;
			line_done  <= 1'b0;
		end else begin
			high_fresh <= (state == DATA_HIGH);
			finish     <= last_pixel;
			line_done  <= finish;

			if (load) begin
				shift_cnt <= '0;
				running   <= 1'b1;
			end else if (shift) begin
				shift_cnt <= shift_cnt + 3'd1;
			end
			// Fine scroll. The first pixels of tile 0 shift out unseen.
			if (shift && (skip != 3'd0)) begin
				skip <= skip - 3'd1;
			end
			if (emit) begin
				pix_cnt <= pix_cnt + 8'd1;
			end
			if (last_pixel) begin
				running <= 1'b0;
			end

			if (finish) begin
				state    <= IDLE;
				tile_col <= '0;
			end else begin
				case (state)
					IDLE: begin
						// A line_start outside IDLE is ignored.
						if (line_start) begin
							state   <= DATA_LOW;
							skip    <= scx[2:0];
							pix_cnt <= '0;
						end
					end
					MAP:       state <= DATA_LOW;
					DATA_LOW:  state <= DATA_HIGH;
					DATA_HIGH: state <= HOLD;
					HOLD: begin
						if (load) begin
							tile_col <= tile_col + 5'd1;
							state    <= (tile_col == TILES_PER_LINE - 1) ? HOLD : MAP;
						end
					end
					default: state <= IDLE;
				endcase
			end
		end
	end

	// Fetched bytes wait here until the shifter takes them.
	always_ff @(posedge clkpipe) begin
		if (state == DATA_LOW) begin
			index_q <= rd_data;
		end
		if (state == DATA_HIGH) begin
			plane_low_byte <= rd_data;
		end
		if (high_fresh) begin
			high_q <= rd_data;
		end
	end

endmodule

// File: bg_pixel_shifter.sv
`timescale 1ns/1ps

module bg_pixel_shifter import ppu_regs_pkg::*, ppu_vram_pkg::*; (
		input  logic       clkpipe,
		input  logic       rst_n,
		input  logic       load,
		input  logic       shift,
		input  logic       emit,
		input  logic       bg_enable,
		input  vram_data_t plane_low_byte,
		input  vram_data_t plane_high_byte,
		input  palette_t   bgp,
		output color_t     pixel,
		output logic       pixel_valid
	);

	vram_data_t low_sr;
	vram_data_t high_sr;
	color_t     color_idx;
	color_t     shade;

	// Leftmost pixel of a tile row is bit 7 of both planes.
	assign color_idx = {high_sr[7], low_sr[7]};
	assign shade     = bgp[{color_idx, 1'b0} +: 2];

	// A load replaces the tile whose last bit is leaving in the same cycle.
	always_ff @(posedge clkpipe) begin
		if (load) begin
			low_sr  <= plane_low_byte;
			high_sr <= plane_high_byte;
		end else if (shift) begin
			low_sr  <= {low_sr[6:0], 1'b0};
			high_sr <= {high_sr[6:0], 1'b0};
		end
	end

	// Pixel reads 0 outside the strobe and while the layer is off.
	always_ff @(posedge clkpipe) begin
		if (!rst_n) begin
			pixel       <= '0;
			pixel_valid <= 1'b0;
		end else begin
			pixel       <= (emit && bg_enable) ? shade : '0;
			pixel_valid <= emit;
		end
	end

endmodule

// File: bg_render.sv
`timescale 1ns/1ps

module bg_render import ppu_regs_pkg::*, ppu_vram_pkg::*; (
		input  logic       clkpipe,
		input  logic       rst_n,
		input  logic       line_start,
		input  scroll_t    line,
		input  scroll_t    scy,
		input  scroll_t    scx,
		input  palette_t   bgp,
		input  logic       map_sel,
		input  logic       data_sel,
		input  logic       bg_enable,
		input  logic       vram_we,
		input  vram_addr_t vram_waddr,
		input  vram_data_t vram_wdata,
		output color_t     pixel,
		output logic       pixel_valid,
		output logic       line_done
	);

	vram_addr_t  rd_addr;
	vram_data_t  rd_data;
	logic [4:0]  tile_col;
	logic        addr_sel;
	logic        plane_high;
	tile_index_t tile_index;
	logic        load;
	logic        shift;
	logic        emit;
	vram_data_t  plane_low_byte;
	vram_data_t  plane_high_byte;

	vram u_vram (
		.clkpipe (clkpipe),
		.we      (vram_we),
		.waddr   (vram_waddr),
		.wdata   (vram_wdata),
		.raddr   (rd_addr),
		.rdata   (rd_data)
	);

	bg_scroll_addr u_scroll_addr (
		.line       (line),
		.scy        (scy),
		.scx        (scx),
		.tile_col   (tile_col),
		.map_sel    (map_sel),
		.data_sel   (data_sel),
		.addr_sel   (addr_sel),
		.plane_high (plane_high),
		.tile_index (tile_index),
		.rd_addr    (rd_addr)
	);

	bg_fetcher u_fetcher (
		.clkpipe         (clkpipe),
		.rst_n           (rst_n),
		.line_start      (line_start),
		.scx             (scx),
		.rd_data         (rd_data),
		.tile_col        (tile_col),
		.addr_sel        (addr_sel),
		.plane_high      (plane_high),
		.tile_index      (tile_index),
		.load            (load),
		.shift           (shift),
		.emit            (emit),
		.plane_low_byte  (plane_low_byte),
		.plane_high_byte (plane_high_byte),
		.line_done       (line_done)
	);

	bg_pixel_shifter u_shifter (
		.clkpipe         (clkpipe),
		.rst_n           (rst_n),
		.load            (load),
		.shift           (shift),
		.emit            (emit),
		.bg_enable       (bg_enable),
		.plane_low_byte  (plane_low_byte),
		.plane_high_byte (plane_high_byte),
		.bgp             (bgp),
		.pixel           (pixel),
		.pixel_valid     (pixel_valid)
	);

endmodule

// File: bg_render_assertions.sv
`timescale 1ns/1ps

module bg_render_assertions import ppu_regs_pkg::*; (
		input logic    clkpipe,
		input logic    rst_n,
		input logic    line_start,
		input scroll_t scx,
		input color_t  pixel,
		input logic    pixel_valid,
		input logic    line_done
	);

	logic        busy;
	logic        accept;
	logic [8:0]  since;
	logic [8:0]  lead;
	int unsigned fail_count = 0;

	// A start is taken when idle, or in the line_done cycle when the fetcher is back in IDLE.
	assign accept = line_start && (!busy || line_done);

	// Cycle count since the accepted start and the expected lead-in for this line.
	always_ff @(posedge clkpipe) begin
		if (!rst_n) begin
			busy  <= 1'b0;
			since <= '0;
			lead  <= '0;
		end else if (accept) begin
			busy  <= 1'b1;
			since <= 9'd1;
			lead  <= 9'd5 + {6'd0, scx[2:0]};
		end else begin
			if (line_done) begin
				busy <= 1'b0;
			end
			if (busy) begin
				since <= since + 9'd1;
			end
		end
	end

	reset_outputs_low: assert property (@(posedge clkpipe)
		!rst_n |=> (!pixel_valid && !line_done && pixel == 2'd0))
		else begin
			$error("outputs not cleared by reset");
			fail_count++;
		end

	quiet_when_idle: assert property (@(posedge clkpipe) disable iff (!rst_n)
		!busy |-> (!pixel_valid && !line_done))
		else begin
			$error("pixel_valid or line_done while no line is active");
			fail_count++;
		end

	strobe_window: assert property (@(posedge clkpipe) disable iff (!rst_n)
		busy |-> (pixel_valid == (since >= lead && since < lead + 9'd160)))
		else begin
			$error("pixel_valid outside its window, cycle %0d lead %0d", since, lead);
			fail_count++;
		end

	done_after_last_pixel: assert property (@(posedge clkpipe) disable iff (!rst_n)
		busy |-> (line_done == (since == lead + 9'd160)))
		else begin
			$error("line_done at the wrong cycle, cycle %0d lead %0d", since, lead);
			fail_count++;
		end

	done_is_pulse: assert property (@(posedge clkpipe) disable iff (!rst_n)
		line_done |=> !line_done)
		else begin
			$error("line_done held longer than one cycle");
			fail_count++;
		end

	blank_between_strobes: assert property (@(posedge clkpipe) disable iff (!rst_n)
		!pixel_valid |-> (pixel == 2'd0))
		else begin
			$error("pixel is not zero outside the strobe");
			fail_count++;
		end

endmodule

// File: tb_bg_render.sv
`timescale 1ns/1ps

module tb_bg_render import ppu_regs_pkg::*, ppu_vram_pkg::*; ();

	localparam int RESET_CYCLES = 10;
	localparam int LOAD_CYCLES  = VRAM_BYTES + 4;
	localparam int NUM_LINES    = 12;
	localparam int LINE_CYCLES  = 200;
	localparam int WATCHDOG_CYCLES =
		RESET_CYCLES + 20 + LOAD_CYCLES + NUM_LINES * LINE_CYCLES + 64;

	logic       clkpipe;
	logic       rst_n;
	logic       line_start;
	scroll_t    line;
	scroll_t    scy;
	scroll_t    scx;
	palette_t   bgp;
	logic       map_sel;
	logic       data_sel;
	logic       bg_enable;
	logic       vram_we;
	vram_addr_t vram_waddr;
	vram_data_t vram_wdata;
	color_t     pixel;
	logic       pixel_valid;
	logic       line_done;

	vram_data_t  image [VRAM_BYTES];
	logic [15:0] lfsr_state = 16'd96;
	string       test_name = "reset_idle";
	int          pix_count = 0;
	int          errors = 0;
	int          err_mark = 0;
	int          tests = 0;

	bg_render i_bg_render (
		.clkpipe     (clkpipe),
		.rst_n       (rst_n),
		.line_start  (line_start),
		.line        (line),
		.scy         (scy),
		.scx         (scx),
		.bgp         (bgp),
		.map_sel     (map_sel),
		.data_sel    (data_sel),
		.bg_enable   (bg_enable),
		.vram_we     (vram_we),
		.vram_waddr  (vram_waddr),
		.vram_wdata  (vram_wdata),
		.pixel       (pixel),
		.pixel_valid (pixel_valid),
		.line_done   (line_done)
	);

	bind bg_render bg_render_assertions u_assertions (
		.clkpipe     (clkpipe),
		.rst_n       (rst_n),
		.line_start  (line_start),
		.scx         (scx),
		.pixel       (pixel),
		.pixel_valid (pixel_valid),
		.line_done   (line_done)
	);

	always #2 clkpipe = ~clkpipe;

	// Galois LFSR with the polynomial x^16 + x^14 + x^13 + x^11 + 1.
	// It steps once per bit taken.
	function automatic logic [7:0] random_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[6:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
		end
		return v;
	endfunction

	function automatic int total_errors();
		return errors + int'(i_bg_render.u_assertions.fail_count);
	endfunction

	// Expected shade of visible pixel idx on the current line from the RAM image.
	function automatic color_t expected_pixel(input int idx);
		scroll_t     x;
		scroll_t     y;
		vram_addr_t  map_addr;
		vram_addr_t  row_addr;
		tile_index_t tile;
		color_t      c;
		x = scx + scroll_t'(idx);
		y = line + scy;
		map_addr = (map_sel ? MAP_BASE_HIGH : MAP_BASE_LOW) + vram_addr_t'(32 * (y / 8) + x / 8);
		tile = image[map_addr];
		if (data_sel) begin
			row_addr = vram_addr_t'(int'(DATA_BASE_UNSIGNED) + 16 * int'(tile));
		end else begin
			row_addr = vram_addr_t'(int'(DATA_BASE_SIGNED) + 16 * int'($signed(tile)));
		end
		row_addr = row_addr + vram_addr_t'(2 * (y % 8));
		c = {image[row_addr + 13'd1][7 - x % 8], image[row_addr][7 - x % 8]};
		if (!bg_enable) begin
			return 2'd0;
		end
		return bgp[2 * c +: 2];
	endfunction

	task automatic write_byte(input vram_addr_t addr, input vram_data_t data);
		@(negedge clkpipe);
		vram_we     = 1'b1;
		vram_waddr  = addr;
		vram_wdata  = data;
		image[addr] = data;
	endtask

	task automatic load_vram();
		vram_data_t data;
		for (int a = 0; a < VRAM_BYTES; a++) begin
			data = random_bits(8);
			// The high map holds tiles 128 to 255, which sit below 0x1000 in signed mode.
			if (a >= int'(MAP_BASE_HIGH)) begin
				data[7] = 1'b1;
			end
			write_byte(vram_addr_t'(a), data);
		end
		@(negedge clkpipe);
		vram_we = 1'b0;
	endtask

	task automatic set_view(input scroll_t x, input scroll_t y, input logic msel,
			input logic dsel, input logic en, input palette_t pal);
		@(negedge clkpipe);
		scx       = x;
		scy       = y;
		map_sel   = msel;
		data_sel  = dsel;
		bg_enable = en;
		bgp       = pal;
	endtask

	// One line. With restart set, a second line_start arrives in the middle of it.
	task automatic run_line(input scroll_t ln, input logic restart);
		int waited;
		@(negedge clkpipe);
		line       = ln;
		pix_count  = 0;
		line_start = 1'b1;
		waited     = 0;
		do begin
			@(negedge clkpipe);
			waited++;
			line_start = restart && (waited == 40);
		end while (!line_done && waited < LINE_CYCLES);
		if (!line_done) begin
			$display("%s: line %0d gave no line_done within %0d cycles",
				test_name, ln, LINE_CYCLES);
			errors++;
		end else if (pix_count != SCREEN_WIDTH) begin
			$display("mismatch %s pixel count: expected %0d, actual %0d",
				test_name, SCREEN_WIDTH, pix_count);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		err_mark  = total_errors();
	endtask

	task automatic report_test();
		tests++;
		$display("test %-16s %s", test_name, (total_errors() == err_mark) ? "ok" : "failed");
	endtask

	// Outputs change on the rising edge, so the falling edge sees them settled.
	always @(negedge clkpipe) begin
		color_t want;
		if (rst_n && pixel_valid) begin
			want = expected_pixel(pix_count);
			if (pixel !== want) begin
				$display("mismatch %s pixel %0d: expected %0d, actual %0d",
					test_name, pix_count, want, pixel);
				errors++;
			end
			pix_count++;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clkpipe);
		$display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		clkpipe    = 1'b0;
		rst_n      = 1'b0;
		line_start = 1'b0;
		line       = '0;
		scy        = '0;
		scx        = '0;
		bgp        = 8'hE4;
		map_sel    = 1'b0;
		data_sel   = 1'b1;
		bg_enable  = 1'b1;
		vram_we    = 1'b0;
		vram_waddr = '0;
		vram_wdata = '0;
		repeat (RESET_CYCLES) @(negedge clkpipe);
		rst_n = 1'b1;

		start_test("reset_idle");
		repeat (20) @(negedge clkpipe);
		report_test();

		load_vram();

		start_test("scroll_zero");
		set_view(8'd0, 8'd0, 1'b0, 1'b1, 1'b1, 8'hE4);
		run_line(8'd0, 1'b0);
		run_line(8'd77, 1'b0);
		report_test();

		start_test("scroll_random");
		set_view(8'd250, 8'd251, 1'b0, 1'b1, 1'b1, 8'hE4);
		run_line(8'd10, 1'b0);
		for (int i = 0; i < 3; i++) begin
			set_view(random_bits(8), random_bits(8), 1'b0, 1'b1, 1'b1, 8'hE4);
			run_line(random_bits(8), 1'b0);
		end
		report_test();

		start_test("signed_high_map");
		for (int i = 0; i < 2; i++) begin
			set_view(random_bits(8), random_bits(8), 1'b1, 1'b0, 1'b1, 8'hE4);
			run_line(random_bits(8), 1'b0);
		end
		// Indices below 128 land above 0x1000 in signed mode, away from their unsigned spot.
		set_view(random_bits(8), random_bits(8), 1'b0, 1'b0, 1'b1, 8'hE4);
		run_line(random_bits(8), 1'b0);
		report_test();

		start_test("bg_disabled");
		set_view(random_bits(8), random_bits(8), 1'b0, 1'b1, 1'b0, random_bits(8));
		run_line(random_bits(8), 1'b0);
		report_test();

		start_test("palette");
		set_view(random_bits(8), random_bits(8), 1'b0, 1'b1, 1'b1, random_bits(8));
		run_line(random_bits(8), 1'b0);
		report_test();

		start_test("restart_ignored");
		set_view(random_bits(8), random_bits(8), 1'b0, 1'b1, 1'b1, 8'hE4);
		run_line(random_bits(8), 1'b1);
		report_test();

		$display("%0d tests run, %0d errors", tests, total_errors());
		if (total_errors() == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: bg_render.f
ppu_regs_pkg.sv
ppu_vram_pkg.sv
vram.sv
bg_scroll_addr.sv
bg_fetcher.sv
bg_pixel_shifter.sv
bg_render.sv
bg_render_assertions.sv
tb_bg_render.sv

// File: Makefile
VERILATOR  := verilator
TOP        := tb_bg_render
FILELIST   := bg_render.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -Wno-fatal --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing -Wall
SIM_ARGS   := +verilator+error+limit+1000
PASS_MSG   := TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
